// File: rtl/crop_adjust.sv
// turns keyboard adjust events into the four soft crop margins
// alt held selects the right and bottom margins instead of left and top
`timescale 1ns/1ps
`default_nettype none

module crop_adjust
	import video_pkg::*;
	import keys_pkg::*;
#(
	parameter count_t H_STEP = 4,               // horizontal margin step
	parameter count_t V_STEP = 1                // vertical margin step
)(
	input  logic      clk_28,
	input  logic      arst_n,
	input  key_data_t kbd_data,
	input  key_type_t kbd_type,
	input  logic      kbd_strobe,
	output count_t    hbl_l,
	output count_t    hbl_r,
	output count_t    vbl_t,
	output count_t    vbl_b
);

	logic    adj_stb;                           // strobe of an adjust event
	logic    old_stb;
	logic    key_evt;                           // one clock per event
	logic    alt;                               // alt modifier held
	key_op_t key_op;

	assign adj_stb = kbd_strobe && (kbd_type == KEY_TYPE_ADJUST);
	assign key_evt = ~old_stb & adj_stb;        // rising edge only

	//////////////////////////////////////////////////
	// key code decode
	//////////////////////////////////////////////////
	always_comb begin
		case (kbd_data)
			KEY_CLEAR:                  key_op = OP_CLEAR;
			KEY_UP:                     key_op = OP_UP;
			KEY_DOWN:                   key_op = OP_DOWN;
			KEY_LEFT:                   key_op = OP_LEFT;
			KEY_RIGHT:                  key_op = OP_RIGHT;
			KEY_ALT_L, KEY_ALT_R:       key_op = OP_ALT_ON;
			KEY_ALT_L_UP, KEY_ALT_R_UP: key_op = OP_ALT_OFF;
			default:                    key_op = OP_NONE;
		endcase
	end

	//////////////////////////////////////////////////
	// margin registers
	//////////////////////////////////////////////////
	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			old_stb <= 1'b0;
			alt     <= 1'b0;
			hbl_l   <= '0;
			hbl_r   <= '0;
			vbl_t   <= '0;
			vbl_b   <= '0;
		end else begin
			old_stb <= adj_stb;
			if (key_evt) begin
				case (key_op)
					OP_CLEAR: begin
						hbl_l <= '0;
						hbl_r <= '0;
						vbl_t <= '0;
						vbl_b <= '0;
					end
					OP_UP: begin
						if (alt) vbl_b <= vbl_b + V_STEP;
						else     vbl_t <= vbl_t + V_STEP;
					end
					OP_DOWN: begin
						if (alt) vbl_b <= vbl_b - V_STEP;
						else     vbl_t <= vbl_t - V_STEP;
					end
					OP_LEFT: begin
						if (alt) hbl_r <= hbl_r + H_STEP;
						else     hbl_l <= hbl_l + H_STEP;
					end
					OP_RIGHT: begin
						if (alt) hbl_r <= hbl_r - H_STEP;
						else     hbl_l <= hbl_l - H_STEP;
					end
					OP_ALT_ON:  alt <= 1'b1;
					OP_ALT_OFF: alt <= 1'b0;
					default: ;                  // unknown key, ignore
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/hblank_crop.sv
// horizontal half of the cropper, counts clocks per line and measures the blank
// gives the combined forced and soft hblank and the active line width
`timescale 1ns/1ps
`default_nettype none

module hblank_crop
	import video_pkg::*;
(
	input  logic   clk_28,
	input  logic   arst_n,
	input  logic   hs,                          // active low
	input  logic   hblank,
	input  count_t hbl_l,
	input  count_t hbl_r,
	output logic   hbl,
	output count_t hsize
);

	logic   old_hs;
	logic   old_hblank;
	logic   shbl;                               // soft blank from margins
	logic   fhbl;                               // forced border blank
	count_t hcnt;
	count_t hend;                               // source blank falls here
	count_t hsta;                               // source blank rises here
	count_t hmax;                               // line length

	logic hs_fall;
	logic hblank_fall;
	logic hblank_rise;

	assign hs_fall     = old_hs & ~hs;
	assign hblank_fall = old_hblank & ~hblank;
	assign hblank_rise = ~old_hblank & hblank;

	assign hbl = fhbl | shbl;

	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			old_hs     <= 1'b0;
			old_hblank <= 1'b0;
			hcnt       <= '0;
			hend       <= '0;
			hsta       <= '0;
			hmax       <= '0;
			hsize      <= '0;
			shbl       <= 1'b1;
			fhbl       <= 1'b1;
		end else begin
			old_hs     <= hs;
			old_hblank <= hblank;

			hcnt <= hcnt + 1'd1;
			if (!hs) hcnt <= '0;                 // held during sync

			// measurement
			if (hblank_fall) hend <= hcnt;
			if (hblank_rise) hsta <= hcnt;
			if (hs_fall)     hmax <= hcnt;
			if (hblank_rise) hsize <= hcnt - hend;

			// soft crop, set wins when both match
			if (hcnt == hend + hbl_l - H_EDGE_LEAD) shbl <= 1'b0;
			if (hcnt == hsta + hbl_r - H_EDGE_LEAD) shbl <= 1'b1;

			//////////////////////////////////////////////////
			// forced border at both line ends
			//////////////////////////////////////////////////
			if (hcnt == H_FORCE_ON)          fhbl <= 1'b0;
			if (hcnt == hmax - H_FORCE_TAIL) fhbl <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/keys_pkg.sv
// key event types and codes used by the crop margin adjuster
// imported by the key decoder and the top level
`default_nettype none

package keys_pkg;

	typedef logic [7:0] key_data_t;             // raw key code
	typedef logic [1:0] key_type_t;             // event class

	localparam key_type_t KEY_TYPE_ADJUST = 2'd3;   // only class we act on

	//////////////////////////////////////////////////
	// key codes
	//////////////////////////////////////////////////
	localparam key_data_t KEY_CLEAR    = 8'h41; // backspace
	localparam key_data_t KEY_UP       = 8'h4C;
	localparam key_data_t KEY_DOWN     = 8'h4D;
	localparam key_data_t KEY_RIGHT    = 8'h4E;
	localparam key_data_t KEY_LEFT     = 8'h4F;
	localparam key_data_t KEY_ALT_L    = 8'h64; // press
	localparam key_data_t KEY_ALT_R    = 8'h65;
	localparam key_data_t KEY_ALT_L_UP = 8'hE4; // release
	localparam key_data_t KEY_ALT_R_UP = 8'hE5;

	// decoded key action
	typedef enum logic [2:0] {
		OP_NONE, OP_CLEAR, OP_UP, OP_DOWN,
		OP_LEFT, OP_RIGHT, OP_ALT_ON, OP_ALT_OFF
	} key_op_t;

endpackage

`default_nettype wire

// File: rtl/screen_monitor.sv
// builds the display enable and takes a per-frame snapshot of the crop state
// the change counter steps whenever the picture mode differs from the last frame
`timescale 1ns/1ps
`default_nettype none

module screen_monitor
	import video_pkg::*;
(
	input  logic   clk_28,
	input  logic   arst_n,
	input  logic   hbl,
	input  logic   vbl,
	input  logic   vblank,                      // source blank, frame start
	input  count_t hbl_l,
	input  count_t hbl_r,
	input  count_t vbl_t,
	input  count_t vbl_b,
	input  count_t hsize,
	input  count_t vsize,
	input  res_t   res,
	output logic   de,
	output count_t scr_hbl_l,
	output count_t scr_hbl_r,
	output count_t scr_vbl_t,
	output count_t scr_vbl_b,
	output count_t scr_hsize,
	output count_t scr_vsize,
	output res_t   scr_res,
	output logic [6:0] scr_flg
);

	logic hde;                                  // registered horizontal enable
	logic old_vblank;
	logic frame_start;
	logic mode_change;

	assign frame_start = old_vblank & ~vblank;
	assign mode_change = (scr_res != res) || (scr_hsize != hsize) || (scr_vsize != vsize);

	assign de = hde & ~vbl;

	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			hde        <= 1'b0;
			old_vblank <= 1'b0;
			scr_hbl_l  <= '0;
			scr_hbl_r  <= '0;
			scr_vbl_t  <= '0;
			scr_vbl_b  <= '0;
			scr_hsize  <= '0;
			scr_vsize  <= '0;
			scr_res    <= '0;
			scr_flg    <= '0;
		end else begin
			hde        <= ~hbl;
			old_vblank <= vblank;
			if (frame_start) begin
				scr_hbl_l <= hbl_l;
				scr_hbl_r <= hbl_r;
				scr_vbl_t <= vbl_t;
				scr_vbl_b <= vbl_b;
				scr_hsize <= hsize;
				scr_vsize <= vsize;
				scr_res   <= res;
				if (mode_change) scr_flg <= scr_flg + 1'd1;   // wraps at 128
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/vblank_crop.sv
// vertical half of the cropper, counts lines and measures the frame blank
// blanks are only updated where the horizontal blank ends
`timescale 1ns/1ps
`default_nettype none

module vblank_crop
	import video_pkg::*;
(
	input  logic   clk_28,
	input  logic   arst_n,
	input  logic   hs,                          // active low
	input  logic   vs,                          // active low
	input  logic   vblank,
	input  logic   hbl,                         // combined horizontal blank
	input  count_t vbl_t,
	input  count_t vbl_b,
	output logic   vbl,
	output count_t vsize
);

	logic   old_hs;
	logic   old_vs;
	logic   old_vblank;
	logic   old_hbl;
	logic   svbl;                               // soft blank from margins
	logic   fvbl;                               // forced border blank
	count_t vcnt;
	count_t vend;
	count_t vsta;
	count_t vmax;                               // frame length in lines

	logic hs_fall;
	logic vs_fall;
	logic vblank_fall;
	logic vblank_rise;
	logic line_start;                           // active part of line begins

	assign hs_fall     = old_hs & ~hs;
	assign vs_fall     = old_vs & ~vs;
	assign vblank_fall = old_vblank & ~vblank;
	assign vblank_rise = ~old_vblank & vblank;
	assign line_start  = old_hbl & ~hbl;

	assign vbl = fvbl | svbl;

	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			old_hs     <= 1'b0;
			old_vs     <= 1'b0;
			old_vblank <= 1'b0;
			old_hbl    <= 1'b0;
			vcnt       <= '0;
			vend       <= '0;
			vsta       <= '0;
			vmax       <= '0;
			vsize      <= '0;
			svbl       <= 1'b1;
			fvbl       <= 1'b1;
		end else begin
			old_hs     <= hs;
			old_vs     <= vs;
			old_vblank <= vblank;
			old_hbl    <= hbl;

			if (hs_fall) vcnt <= vcnt + 1'd1;
			if (!vs)     vcnt <= '0;             // held during vsync

			if (vblank_fall) vend <= vcnt;
			if (vblank_rise) vsta <= vcnt;
			if (vs_fall)     vmax <= vcnt;
			if (vblank_rise) vsize <= vcnt - vend;

			//////////////////////////////////////////////////
			// once per line, at the first active pixel
			//////////////////////////////////////////////////
			if (line_start) begin
				if (vcnt == vend + vbl_t - V_EDGE_LEAD) svbl <= 1'b0;
				if (vcnt == vsta + vbl_b - V_EDGE_LEAD) svbl <= 1'b1;

				if (vcnt == V_FORCE_ON)          fvbl <= 1'b0;
				if (vcnt == vmax - V_FORCE_TAIL) fvbl <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/video_crop_top.sv
// active-picture cropper placed after the video source
// wires the key decoder, the two blank parts and the screen monitor together
`timescale 1ns/1ps
`default_nettype none

module video_crop_top
	import video_pkg::*;
	import keys_pkg::*;
#(
	parameter count_t H_STEP = 4,
	parameter count_t V_STEP = 1
)(
	input  logic       clk_28,
	input  logic       arst_n,
	input  logic       hs,
	input  logic       vs,
	input  logic       hblank,
	input  logic       vblank,
	input  res_t       res,
	input  key_data_t  kbd_data,
	input  key_type_t  kbd_type,
	input  logic       kbd_strobe,
	output logic       de,
	output count_t     scr_hbl_l,
	output count_t     scr_hbl_r,
	output count_t     scr_vbl_t,
	output count_t     scr_vbl_b,
	output count_t     scr_hsize,
	output count_t     scr_vsize,
	output res_t       scr_res,
	output logic [6:0] scr_flg
);

	count_t hbl_l, hbl_r, vbl_t, vbl_b;         // live margins
	count_t hsize, vsize;                       // measured picture size
	logic   hbl, vbl;

	crop_adjust #(
		.H_STEP (H_STEP),
		.V_STEP (V_STEP)
	) crop_adjust_inst (
		.clk_28 (clk_28), .arst_n (arst_n),
		.kbd_data (kbd_data), .kbd_type (kbd_type), .kbd_strobe (kbd_strobe),
		.hbl_l (hbl_l), .hbl_r (hbl_r), .vbl_t (vbl_t), .vbl_b (vbl_b)
	);

	hblank_crop hblank_crop_inst (
		.clk_28 (clk_28), .arst_n (arst_n),
		.hs (hs), .hblank (hblank), .hbl_l (hbl_l), .hbl_r (hbl_r),
		.hbl (hbl), .hsize (hsize)
	);

	vblank_crop vblank_crop_inst (
		.clk_28 (clk_28), .arst_n (arst_n),
		.hs (hs), .vs (vs), .vblank (vblank), .hbl (hbl),
		.vbl_t (vbl_t), .vbl_b (vbl_b), .vbl (vbl), .vsize (vsize)
	);

	screen_monitor screen_monitor_inst (
		.clk_28 (clk_28), .arst_n (arst_n),
		.hbl (hbl), .vbl (vbl), .vblank (vblank),
		.hbl_l (hbl_l), .hbl_r (hbl_r), .vbl_t (vbl_t), .vbl_b (vbl_b),
		.hsize (hsize), .vsize (vsize), .res (res), .de (de),
		.scr_hbl_l (scr_hbl_l), .scr_hbl_r (scr_hbl_r),
		.scr_vbl_t (scr_vbl_t), .scr_vbl_b (scr_vbl_b),
		.scr_hsize (scr_hsize), .scr_vsize (scr_vsize),
		.scr_res (scr_res), .scr_flg (scr_flg)
	);

endmodule

`default_nettype wire

// File: rtl/video_pkg.sv
// video timing types and the fixed border limits shared by the cropper blocks
// imported by every RTL module that handles counts, margins or sizes
`default_nettype none

package video_pkg;

	parameter int COUNT_W = 12;                 // width of all timing counts

	typedef logic [COUNT_W-1:0] count_t;        // counters, margins, sizes
	typedef logic [1:0]         res_t;          // source resolution code

	//////////////////////////////////////////////////
	// forced border, horizontal
	//////////////////////////////////////////////////
	localparam count_t H_FORCE_ON   = 8;        // forced hblank ends here
	localparam count_t H_FORCE_TAIL = 8;        // counts before line end

	//////////////////////////////////////////////////
	// forced border, vertical
	//////////////////////////////////////////////////
	localparam count_t V_FORCE_ON   = 1;        // forced vblank ends on this line
	localparam count_t V_FORCE_TAIL = 3;        // lines before frame end

	// soft edges fire early to line up with the registered blank
	localparam count_t H_EDGE_LEAD  = 2;
	localparam count_t V_EDGE_LEAD  = 1;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# builds the cropper testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f src.f --top-module tb_video_crop -o tb_video_crop

rm -f sim.log
if ./obj_dir/tb_video_crop > sim.log 2>&1; then
	echo "simulation exited normally"
else
	echo "simulation exited with an error status"
fi
cat sim.log

if grep -q "^Finished with no errors$" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

// File: src.f
rtl/video_pkg.sv
rtl/keys_pkg.sv
rtl/crop_adjust.sv
rtl/hblank_crop.sv
rtl/vblank_crop.sv
rtl/screen_monitor.sv
rtl/video_crop_top.sv
+incdir+tests
tests/tb_video_crop.sv

// File: tests/crop_model.svh
// reference model of the cropper, stepped once per clock next to the DUT
// included inside the testbench module, reads the same driven inputs
`ifndef CROP_MODEL_SVH
`define CROP_MODEL_SVH

logic   m_old_stb, m_alt;
count_t m_hbl_l, m_hbl_r, m_vbl_t, m_vbl_b;
logic   m_old_hs, m_old_hblank, m_shbl, m_fhbl;
count_t m_hcnt, m_hend, m_hsta, m_hmax, m_hsize;
logic   m_v_old_hs, m_old_vs, m_old_vblank, m_old_hbl, m_svbl, m_fvbl;
count_t m_vcnt, m_vend, m_vsta, m_vmax, m_vsize;
logic   m_hde, m_mon_old_vblank;
count_t m_scr_hbl_l, m_scr_hbl_r, m_scr_vbl_t, m_scr_vbl_b, m_scr_hsize, m_scr_vsize;
res_t   m_scr_res;
logic [6:0] m_scr_flg;

function automatic logic model_hbl();
	return m_fhbl | m_shbl;
endfunction

function automatic logic model_vbl();
	return m_fvbl | m_svbl;
endfunction

function automatic logic model_de();
	return m_hde & ~model_vbl();
endfunction

task automatic model_reset();
	m_old_stb = 0; m_alt = 0;
	m_hbl_l = '0; m_hbl_r = '0; m_vbl_t = '0; m_vbl_b = '0;
	m_old_hs = 0; m_old_hblank = 0; m_shbl = 1; m_fhbl = 1;
	m_hcnt = '0; m_hend = '0; m_hsta = '0; m_hmax = '0; m_hsize = '0;
	m_v_old_hs = 0; m_old_vs = 0; m_old_vblank = 0; m_old_hbl = 0;
	m_svbl = 1; m_fvbl = 1;
	m_vcnt = '0; m_vend = '0; m_vsta = '0; m_vmax = '0; m_vsize = '0;
	m_hde = 0; m_mon_old_vblank = 0;
	m_scr_hbl_l = '0; m_scr_hbl_r = '0; m_scr_vbl_t = '0; m_scr_vbl_b = '0;
	m_scr_hsize = '0; m_scr_vsize = '0; m_scr_res = '0; m_scr_flg = '0;
endtask

// nonblocking updates so every rule reads the state of the previous clock
task automatic model_step();
	logic adj;
	logic hbl_now;
	adj = kbd_strobe && (kbd_type == KEY_TYPE_ADJUST);
	hbl_now = model_hbl();
	m_old_stb <= adj;
	if (adj && !m_old_stb) begin
		if (kbd_data == KEY_CLEAR) begin
			m_hbl_l <= '0; m_hbl_r <= '0; m_vbl_t <= '0; m_vbl_b <= '0;
		end
		else if (kbd_data == KEY_UP && m_alt)    m_vbl_b <= m_vbl_b + V_STEP_TB;
		else if (kbd_data == KEY_UP)             m_vbl_t <= m_vbl_t + V_STEP_TB;
		else if (kbd_data == KEY_DOWN && m_alt)  m_vbl_b <= m_vbl_b - V_STEP_TB;
		else if (kbd_data == KEY_DOWN)           m_vbl_t <= m_vbl_t - V_STEP_TB;
		else if (kbd_data == KEY_LEFT && m_alt)  m_hbl_r <= m_hbl_r + H_STEP_TB;
		else if (kbd_data == KEY_LEFT)           m_hbl_l <= m_hbl_l + H_STEP_TB;
		else if (kbd_data == KEY_RIGHT && m_alt) m_hbl_r <= m_hbl_r - H_STEP_TB;
		else if (kbd_data == KEY_RIGHT)          m_hbl_l <= m_hbl_l - H_STEP_TB;
		else if (kbd_data == 8'h64 || kbd_data == 8'h65) m_alt <= 1'b1;
		else if (kbd_data == 8'hE4 || kbd_data == 8'hE5) m_alt <= 1'b0;
	end

	// horizontal part
	m_old_hs <= hs;
	m_old_hblank <= hblank;
	m_hcnt <= hs ? m_hcnt + count_t'(1) : '0;
	if (m_old_hblank && !hblank) m_hend <= m_hcnt;
	if (!m_old_hblank && hblank) m_hsta <= m_hcnt;
	if (!m_old_hblank && hblank) m_hsize <= m_hcnt - m_hend;
	if (m_old_hs && !hs) m_hmax <= m_hcnt;
	if (m_hcnt == m_hsta + m_hbl_r - H_EDGE_LEAD) m_shbl <= 1'b1;
	else if (m_hcnt == m_hend + m_hbl_l - H_EDGE_LEAD) m_shbl <= 1'b0;
	if (m_hcnt == m_hmax - H_FORCE_TAIL) m_fhbl <= 1'b1;
	else if (m_hcnt == H_FORCE_ON) m_fhbl <= 1'b0;

	// vertical part
	m_v_old_hs <= hs;
	m_old_vs <= vs;
	m_old_vblank <= vblank;
	m_old_hbl <= hbl_now;
	if (!vs) m_vcnt <= '0;
	else if (m_v_old_hs && !hs) m_vcnt <= m_vcnt + count_t'(1);
	if (m_old_vblank && !vblank) m_vend <= m_vcnt;
	if (!m_old_vblank && vblank) m_vsta <= m_vcnt;
	if (!m_old_vblank && vblank) m_vsize <= m_vcnt - m_vend;
	if (m_old_vs && !vs) m_vmax <= m_vcnt;
	if (m_old_hbl && !hbl_now) begin
		if (m_vcnt == m_vsta + m_vbl_b - V_EDGE_LEAD) m_svbl <= 1'b1;
		else if (m_vcnt == m_vend + m_vbl_t - V_EDGE_LEAD) m_svbl <= 1'b0;
		if (m_vcnt == m_vmax - V_FORCE_TAIL) m_fvbl <= 1'b1;
		else if (m_vcnt == V_FORCE_ON) m_fvbl <= 1'b0;
	end

	// monitor
	m_hde <= ~hbl_now;
	m_mon_old_vblank <= vblank;
	if (m_mon_old_vblank && !vblank) begin
		m_scr_hbl_l <= m_hbl_l; m_scr_hbl_r <= m_hbl_r;
		m_scr_vbl_t <= m_vbl_t; m_scr_vbl_b <= m_vbl_b;
		m_scr_hsize <= m_hsize; m_scr_vsize <= m_vsize; m_scr_res <= res;
		if (m_scr_res != res || m_scr_hsize != m_hsize || m_scr_vsize != m_vsize)
			m_scr_flg <= m_scr_flg + 7'd1;
	end
endtask

`endif

// File: tests/tb_video_crop.sv
// testbench for the cropper, random video frames and key events against a model
// compares de and every snapshot output on each clock
`timescale 1ns/1ps
`default_nettype none

module tb_video_crop
	import video_pkg::*;
	import keys_pkg::*;
;

	localparam count_t H_STEP_TB   = 6;
	localparam count_t V_STEP_TB   = 2;
	localparam int     FRAMES      = 40;
	localparam int     CYCLE_LIMIT = FRAMES * 30 * 90 + 2000;   // longest frames plus slack

	logic       clk_28;
	logic       arst_n;
	logic       hs, vs, hblank, vblank;
	res_t       res;
	key_data_t  kbd_data;
	key_type_t  kbd_type;
	logic       kbd_strobe;
	logic       de;
	count_t     scr_hbl_l, scr_hbl_r, scr_vbl_t, scr_vbl_b, scr_hsize, scr_vsize;
	res_t       scr_res;
	logic [6:0] scr_flg;

	int   cycles;
	int   error_count;
	logic checking;

	key_data_t key_list [9] = '{8'h41, 8'h4C, 8'h4D, 8'h4E, 8'h4F, 8'h64, 8'h65, 8'hE4, 8'hE5};

	`include "crop_model.svh"

	video_crop_top #(
		.H_STEP (H_STEP_TB),
		.V_STEP (V_STEP_TB)
	) video_crop_top_inst (
		.clk_28 (clk_28), .arst_n (arst_n),
		.hs (hs), .vs (vs), .hblank (hblank), .vblank (vblank), .res (res),
		.kbd_data (kbd_data), .kbd_type (kbd_type), .kbd_strobe (kbd_strobe),
		.de (de),
		.scr_hbl_l (scr_hbl_l), .scr_hbl_r (scr_hbl_r),
		.scr_vbl_t (scr_vbl_t), .scr_vbl_b (scr_vbl_b),
		.scr_hsize (scr_hsize), .scr_vsize (scr_vsize),
		.scr_res (scr_res), .scr_flg (scr_flg)
	);

	initial begin
		clk_28 = 1'b0;
		forever #20 clk_28 = ~clk_28;
	end

	function automatic int rand_range(input int lo, input int hi);
		int span;
		span = hi - lo + 1;
		return lo + int'($urandom % span);
	endfunction

	task automatic compare_count(input string what, input count_t got, input count_t exp);
		assert (got === exp) else begin
			error_count++;
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			$display("Finished with errors");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	//////////////////////////////////////////////////
	// model and checker
	//////////////////////////////////////////////////
	always @(posedge clk_28) begin
		if (!arst_n) model_reset();
		else         model_step();
	end

	always @(negedge clk_28) begin
		if (checking) begin
			if (!arst_n)
				compare_count("de in reset", count_t'(de), '0);
			compare_count("de", count_t'(de), count_t'(model_de()));
			compare_count("scr_hbl_l", scr_hbl_l, m_scr_hbl_l);
			compare_count("scr_hbl_r", scr_hbl_r, m_scr_hbl_r);
			compare_count("scr_vbl_t", scr_vbl_t, m_scr_vbl_t);
			compare_count("scr_vbl_b", scr_vbl_b, m_scr_vbl_b);
			compare_count("scr_hsize", scr_hsize, m_scr_hsize);
			compare_count("scr_vsize", scr_vsize, m_scr_vsize);
			compare_count("scr_res", count_t'(scr_res), count_t'(m_scr_res));
			compare_count("scr_flg", count_t'(scr_flg), count_t'(m_scr_flg));
		end
	end

	always @(posedge clk_28) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run timed out after %0d cycles", cycles);
			$display("Finished with errors");
			$fatal(1, "timeout");
		end
	end

	// one key event with a random code, sometimes of a type that is ignored
	task automatic pick_key();
		kbd_data = key_list[rand_range(0, 8)];
		if (rand_range(0, 4) == 0) kbd_type = key_type_t'(rand_range(0, 2));
		else                       kbd_type = KEY_TYPE_ADJUST;
	endtask

	//////////////////////////////////////////////////
	// one frame of video, keys during its first line
	//////////////////////////////////////////////////
	task automatic run_frame();
		int len, height, hb_end, hb_sta, vb_end, vb_sta;
		len    = rand_range(60, 90);
		height = rand_range(20, 30);
		hb_end = rand_range(10, 18);
		hb_sta = len - rand_range(10, 16);
		vb_end = rand_range(2, 4);
		vb_sta = height - rand_range(3, 4);
		if (rand_range(0, 3) == 0) res = res_t'(rand_range(0, 3));
		for (int line = 0; line < height; line++) begin
			for (int c = 0; c < len; c++) begin
				@(posedge clk_28);
				#1;
				hs     = !(c >= len - 6 && c < len - 2);
				hblank = (c < hb_end) || (c >= hb_sta);
				vblank = (line < vb_end) || (line >= vb_sta);
				vs     = !(line >= height - 2);
				if (line == 0 && (c == 4 || c == 12 || c == 20)) begin
					pick_key();
					kbd_strobe = 1'b1;
				end
				if (line == 0 && (c == 8 || c == 16 || c == 24))
					kbd_strobe = 1'b0;
			end
		end
	endtask

	initial begin
		void'($urandom(32'h352c));
		model_reset();
		cycles      = 0;
		error_count = 0;
		checking    = 1'b0;
		arst_n      = 1'b0;
		hs          = 1'b1;
		vs          = 1'b1;
		hblank      = 1'b1;
		vblank      = 1'b1;
		res         = '0;
		kbd_data    = '0;
		kbd_type    = '0;
		kbd_strobe  = 1'b0;

		@(posedge clk_28);
		checking = 1'b1;
		repeat (9) @(posedge clk_28);
		#1 arst_n = 1'b1;

		for (int f = 0; f < FRAMES; f++)
			run_frame();
		repeat (20) @(posedge clk_28);

		if (error_count == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("Finished with errors");
			$fatal(1, "checks failed");
		end
	end

endmodule

`default_nettype wire
